// File: fifo_level_monitor.sv
// Level status of the FIFO
// Used words lag a pointer change by one edge
// Full lags the used words by one more edge
// Full sets at 24 words, clears below 8, holds in between
// Empty follows the registered count without a further delay

`timescale 1ns/1ns

module fifo_level_monitor
	import fifo_pkg::*;
(
	input logic				RST_IN,		// Clock
	input logic				CLK_IN,		// Async reset, active high
	input fifo_adr_t		wp,			// Write pointer
	input fifo_adr_t		rp,			// Read pointer
	output fifo_status_t	status		// Used words, full, empty
);

	// Registered used-word count
	fifo_wrds_t used_wrds;

	// Hysteresis full flag
	logic full;

	// Empty flag
	logic empty;

	// Used words
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			used_wrds <= '0;
		// Write pointer ahead or level
		else if (wp >= rp)
			used_wrds <= fifo_wrds_t'(wp) - fifo_wrds_t'(rp);
		// Write pointer has wrapped
		else
			used_wrds <= fifo_wrds_t'(fifo_depth) - fifo_wrds_t'(rp) + fifo_wrds_t'(wp);
	end

	// Full flag
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			full <= 1'b0;
		// Set at three quarters
		else if (used_wrds >= fifo_wrds_t'(fifo_full_set))
			full <= 1'b1;
		// Clear below one quarter
		else if (used_wrds < fifo_wrds_t'(fifo_full_clr))
			full <= 1'b0;
	end

	// Empty flag straight from the registered count
	assign empty = (used_wrds == '0);

	// Status bundle
	always_comb
	begin
		status.used_wrds = used_wrds;
		status.full = full;
		status.empty = empty;
	end

endmodule

// File: fifo_pkg.sv
// Shared sizes and bundle types for the single-clock FIFO
// Depth is fixed at 32 words; widths change only here
// Full thresholds assume a depth that is a multiple of four
// No overflow guard anywhere in the FIFO
// The writer keeps at most 31 unread words

package fifo_pkg;

	// Pointer and data widths
	localparam int fifo_adr_w = 5;
	localparam int fifo_dat_w = 32;

	// Words in the storage array
	localparam int fifo_depth = 1 << fifo_adr_w;

	// Full flag thresholds, set at 3/4 and clear below 1/4
	localparam int fifo_full_set = 3 * (fifo_depth / 4);
	localparam int fifo_full_clr = fifo_depth / 4;

	// Write or read pointer
	typedef logic [fifo_adr_w-1:0] fifo_adr_t;

	// One data word
	typedef logic [fifo_dat_w-1:0] fifo_dat_t;

	// Used words, one bit wider than a pointer
	typedef logic [fifo_adr_w:0] fifo_wrds_t;

	// Level status seen by the writer
	typedef struct packed
	{
		fifo_wrds_t	used_wrds;	// Words stored, wp minus rp
		logic		full;		// Hysteresis full flag
		logic		empty;		// Combinational empty
	} fifo_status_t;

	// Read side bundle
	typedef struct packed
	{
		fifo_dat_t	dat;		// Registered read word
		logic		sde;		// Single data enable, head word shown
		logic		bde;		// Burst data enable, one per read
	} fifo_rd_out_t;

endpackage

// File: fifo_ram.sv
// Storage array for the FIFO
// One write port at wp, one read port at rp, both every clock
// Read data goes through two registers for block RAM inference
// Read during write to the same word is not guarded
// No reset on the array or the read registers

`timescale 1ns/1ns

module fifo_ram
	import fifo_pkg::*;
(
	input logic			RST_IN,		// Clock
	input fifo_dat_t	wr_dat,		// Write data
	input logic			ram_we,		// Write enable
	input fifo_adr_t	wp,			// Write address
	input fifo_adr_t	rp,			// Read address
	output fifo_dat_t	rd_dat		// Read data, two edges after rp
);

	// Storage
	fifo_dat_t mem [0:fifo_depth-1];

	// Read stages
	fifo_dat_t dout;
	fifo_dat_t dout_reg;

	// Write port
	always_ff @(posedge RST_IN)
	begin
		if (ram_we)
			mem[wp] <= wr_dat;
	end

	// Read port, first stage is the RAM output register
	always_ff @(posedge RST_IN)
	begin
		dout <= mem[rp];
	end

	// Second stage lines up with the data enables
	always_ff @(posedge RST_IN)
	begin
		dout_reg <= dout;
	end

	assign rd_dat = dout_reg;

endmodule

// File: fifo_read_ctrl.sv
// Consumer side of the FIFO
// Reads with equal pointers are ignored, no error is flagged
// Single data enable shows the head word without consuming it
// Burst data enable marks each word returned by a read
// Both enables come two edges after the pointer they refer to

`timescale 1ns/1ns

module fifo_read_ctrl
	import fifo_pkg::*;
(
	input logic				RST_IN,		// Clock
	input logic				CLK_IN,		// Async reset, active high
	input logic				rd,			// Read strobe
	input fifo_adr_t		wp,			// Write pointer
	input fifo_dat_t		rd_dat,		// Data from the RAM read stages
	output fifo_adr_t		rp,			// Read pointer
	output fifo_rd_out_t	rd_out		// Data word and both enables
);

	// Read pointer register
	fifo_adr_t rp_reg;

	// Nothing stored when the pointers meet
	logic peq;

	// Single mode stage and its delay
	logic sde;
	logic sde_del;

	// Burst mode stage and its delay
	logic bde;
	logic bde_del;

	// Pointers equal
	assign peq = (wp == rp_reg);

	// Read pointer, advances only on an accepted read
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			rp_reg <= '0;
		else if (rd && !peq)
		begin
			if (rp_reg == fifo_adr_t'(fifo_depth - 1))
				rp_reg <= '0;
			else
				rp_reg <= rp_reg + 1'b1;
		end
	end

	// Single mode
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			sde <= 1'b0;
			sde_del <= 1'b0;
		end
		// Empty or consumed, drop both stages at once
		else if (peq || rd)
		begin
			sde <= 1'b0;
			sde_del <= 1'b0;
		end
		else
		begin
			sde <= 1'b1;
			sde_del <= sde;
		end
	end

	// Burst mode
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			bde <= 1'b0;
			bde_del <= 1'b0;
		end
		else
		begin
			// Only accepted reads produce a word
			bde <= rd && !peq;
			// Delay matches the second RAM read stage
			bde_del <= bde;
		end
	end

	// Output bundle
	always_comb
	begin
		rd_out.dat = rd_dat;
		rd_out.sde = sde_del;
		rd_out.bde = bde_del;
	end

	assign rp = rp_reg;

endmodule

// File: fifo_sc_asserts.sv
// Concurrent checks on the FIFO top level, attached by bind
// Sees the internal pointers through the bind port list
// Quiet while reset is high

`timescale 1ns/1ns

module fifo_sc_asserts
	import fifo_pkg::*;
(
	input logic				RST_IN,		// Clock
	input logic				CLK_IN,		// Async reset, active high
	input fifo_adr_t		wp,			// Write pointer
	input fifo_adr_t		rp,			// Read pointer
	input logic				wr,			// Write strobe
	input logic				rd,			// Read strobe
	input fifo_rd_out_t		rd_out		// Read word and enables
);

	// Read pointer holds while nothing is stored
	rp_hold_on_empty: assert property (@(posedge RST_IN) disable iff (CLK_IN)
		(rp == wp) |=> $stable(rp))
		else $error("rp moved while equal to wp");

	// Only one enable at a time
	one_enable: assert property (@(posedge RST_IN) disable iff (CLK_IN)
		!(rd_out.sde && rd_out.bde))
		else $error("single and burst data enables both high");

	// Fixed two-edge read latency
	burst_latency: assert property (@(posedge RST_IN) disable iff (CLK_IN)
		(rd && (rp != wp)) |-> ##2 rd_out.bde)
		else $error("burst data enable missing two edges after a read");

	// Writer keeps at most 31 words
	// A write with no accepted read never lets wp catch up with rp
	count_limit: assert property (@(posedge RST_IN) disable iff (CLK_IN)
		(wr && !(rd && (rp != wp))) |-> (fifo_adr_t'(wp + 1'b1) != rp))
		else $error("write with 31 words stored and no read");

endmodule

// File: fifo_sc_top.sv
// Single-clock FIFO for the video data path
// 32 words of 32 bits, sizes come from the package
// Plain write and read strobes, no handshake
// Writer must watch full and never exceed 31 unread words
// Read data and both enables arrive two edges after the read
// Reads while empty are ignored

`timescale 1ns/1ns

module fifo_sc_top
	import fifo_pkg::*;
(
	input logic				RST_IN,		// Clock
	input logic				CLK_IN,		// Async reset, active high
	input logic				wr,			// Write strobe
	input fifo_dat_t		wr_dat,		// Write data
	input logic				rd,			// Read strobe
	output fifo_rd_out_t	rd_out,		// Read word and data enables
	output fifo_status_t	status		// Level status
);

	// Pointers shared by all blocks
	fifo_adr_t wp;
	fifo_adr_t rp;

	// RAM write enable from the producer
	logic ram_we;

	// RAM read word to the consumer
	fifo_dat_t rd_dat;

	// Producer
	fifo_write_ctrl u_write_ctrl
	(
		.RST_IN	(RST_IN),
		.CLK_IN	(CLK_IN),
		.wr		(wr),
		.wp		(wp),
		.ram_we	(ram_we)
	);

	// Buffer
	fifo_ram u_ram
	(
		.RST_IN	(RST_IN),
		.wr_dat	(wr_dat),
		.ram_we	(ram_we),
		.wp		(wp),
		.rp		(rp),
		.rd_dat	(rd_dat)
	);

	// Consumer
	fifo_read_ctrl u_read_ctrl
	(
		.RST_IN	(RST_IN),
		.CLK_IN	(CLK_IN),
		.rd		(rd),
		.wp		(wp),
		.rd_dat	(rd_dat),
		.rp		(rp),
		.rd_out	(rd_out)
	);

	// Level status
	fifo_level_monitor u_level_monitor
	(
		.RST_IN	(RST_IN),
		.CLK_IN	(CLK_IN),
		.wp		(wp),
		.rp		(rp),
		.status	(status)
	);

endmodule

// File: fifo_write_ctrl.sv
// Producer side of the FIFO
// Every clock with wr high writes a word, full or not
// Pointer wraps at the depth

`timescale 1ns/1ns

module fifo_write_ctrl
	import fifo_pkg::*;
(
	input logic			RST_IN,		// Clock
	input logic			CLK_IN,		// Async reset, active high
	input logic			wr,			// Write strobe
	output fifo_adr_t	wp,			// Write pointer
	output logic		ram_we		// RAM write enable
);

	// Write pointer register
	fifo_adr_t wp_reg;

	// Advance on each write
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			wp_reg <= '0;
		else if (wr)
		begin
			// Wrap at the last word
			if (wp_reg == fifo_adr_t'(fifo_depth - 1))
				wp_reg <= '0;
			else
				wp_reg <= wp_reg + 1'b1;
		end
	end

	// RAM stores at the current pointer in the same edge
	assign ram_we = wr;

	// Pointer out to RAM, reader and level monitor
	assign wp = wp_reg;

endmodule

// File: sources.f
fifo_pkg.sv
fifo_write_ctrl.sv
fifo_ram.sv
fifo_read_ctrl.sv
fifo_level_monitor.sv
fifo_sc_top.sv
fifo_sc_asserts.sv
tb_fifo_sc.sv

// File: tb_fifo_sc.sv
// Directed testbench for the single-clock FIFO
// Inputs change on the falling clock edge, outputs are sampled there too
// A reference queue models the contents, words in flight and the status lag
// Writer never leaves more than 31 unread words
// Stops at the first mismatch

`timescale 1ns/1ns

module tb_fifo_sc
	import fifo_pkg::*;
();

	// DUT ports
	logic			RST_IN;
	logic			CLK_IN;
	logic			wr;
	fifo_dat_t		wr_dat;
	logic			rd;
	fifo_rd_out_t	rd_out;
	fifo_status_t	status;

	// Reference model state
	fifo_dat_t	ref_q[$];
	fifo_wrds_t	cnt_m;
	logic		full_m;
	logic		acc_d1;
	fifo_dat_t	word_d1;

	string	test_name;
	int		err_cnt;

	fifo_sc_top UUT
	(
		.RST_IN	(RST_IN),
		.CLK_IN	(CLK_IN),
		.wr		(wr),
		.wr_dat	(wr_dat),
		.rd		(rd),
		.rd_out	(rd_out),
		.status	(status)
	);

	bind fifo_sc_top fifo_sc_asserts u_asserts
	(
		.RST_IN	(RST_IN),
		.CLK_IN	(CLK_IN),
		.wp		(wp),
		.rp		(rp),
		.wr		(wr),
		.rd		(rd),
		.rd_out	(rd_out)
	);

	// 8 ns clock
	initial
	begin
		RST_IN = 1'b0;
		forever #4 RST_IN = ~RST_IN;
	end

	// Stop the run with a plain message
	task automatic fail_run(input string msg);
		err_cnt++;
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare_dat(input string what, input fifo_dat_t exp, input fifo_dat_t act);
		if (act !== exp)
			fail_run($sformatf("ERROR: %s %s expected %h actual %h", test_name, what, exp, act));
	endtask

	task automatic compare_status(input fifo_status_t exp, input fifo_status_t act);
		if (act !== exp)
			fail_run($sformatf("ERROR: %s status expected %h actual %h", test_name, exp, act));
	endtask

	task automatic compare_flag(input string what, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("ERROR: %s %s expected %b actual %b", test_name, what, exp, act));
	endtask

	// One clock: drive, update the model, check bde, data and status
	task automatic run_cycle(input logic wr_v, input fifo_dat_t dat_v, input logic rd_v);
		logic			acc;
		logic			nxt_full;
		fifo_wrds_t		nxt_cnt;
		fifo_dat_t		head;
		fifo_status_t	exp_st;
		// Read counts only if something is stored before this edge
		acc = rd_v && (ref_q.size() > 0);
		nxt_cnt = fifo_wrds_t'(ref_q.size());
		// Full follows the previous count
		if (cnt_m >= fifo_full_set)
			nxt_full = 1'b1;
		else if (cnt_m < fifo_full_clr)
			nxt_full = 1'b0;
		else
			nxt_full = full_m;
		head = '0;
		if (acc)
			head = ref_q.pop_front();
		if (wr_v)
			ref_q.push_back(dat_v);
		wr = wr_v;
		wr_dat = dat_v;
		rd = rd_v;
		@(posedge RST_IN);
		@(negedge RST_IN);
		cnt_m = nxt_cnt;
		full_m = nxt_full;
		// Word of the read one clock earlier is due now
		compare_flag("burst data enable", acc_d1, rd_out.bde);
		if (acc_d1)
			compare_dat("burst word", word_d1, rd_out.dat);
		acc_d1 = acc;
		word_d1 = head;
		exp_st.used_wrds = cnt_m;
		exp_st.full = full_m;
		exp_st.empty = (cnt_m == 0);
		compare_status(exp_st, status);
	endtask

	task automatic idle(input int n);
		repeat (n) run_cycle(1'b0, '0, 1'b0);
	endtask

	function automatic fifo_status_t make_status(input int n, input logic f);
		fifo_status_t s;
		s.used_wrds = fifo_wrds_t'(n);
		s.full = f;
		s.empty = (n == 0);
		return s;
	endfunction

	task automatic test_reset_state();
		test_name = "reset_state";
		compare_status(make_status(0, 1'b0), status);
		compare_flag("single data enable", 1'b0, rd_out.sde);
		compare_flag("burst data enable", 1'b0, rd_out.bde);
	endtask

	task automatic test_burst_order();
		test_name = "burst_order";
		repeat (10) run_cycle(1'b1, fifo_dat_t'($urandom()), 1'b0);
		repeat (10) run_cycle(1'b0, '0, 1'b1);
		idle(3);
		compare_status(make_status(0, 1'b0), status);
	endtask

	task automatic test_single_mode();
		fifo_dat_t	w;
		int			i;
		test_name = "single_mode";
		w = fifo_dat_t'($urandom());
		run_cycle(1'b1, w, 1'b0);
		// Head word shows up without a read
		i = 0;
		while (rd_out.sde !== 1'b1 && i < 10)
		begin
			idle(1);
			i++;
		end
		if (rd_out.sde !== 1'b1)
			fail_run("Timeout: single data enable never rose in single_mode");
		compare_dat("head word", w, rd_out.dat);
		run_cycle(1'b0, '0, 1'b1);
		idle(3);
		compare_flag("single data enable", 1'b0, rd_out.sde);
		compare_status(make_status(0, 1'b0), status);
	endtask

	task automatic test_full_hysteresis();
		test_name = "full_hysteresis";
		for (int n = 1; n <= 24; n++)
		begin
			run_cycle(1'b1, fifo_dat_t'($urandom()), 1'b0);
			idle(2);
			compare_status(make_status(n, n >= 24), status);
		end
		// Full holds until the count drops below a quarter
		for (int n = 23; n >= 0; n--)
		begin
			run_cycle(1'b0, '0, 1'b1);
			idle(2);
			compare_status(make_status(n, n >= 8), status);
		end
	endtask

	task automatic test_read_empty();
		test_name = "read_empty";
		repeat (4) run_cycle(1'b0, '0, 1'b1);
		idle(2);
		compare_status(make_status(0, 1'b0), status);
		run_cycle(1'b1, fifo_dat_t'($urandom()), 1'b0);
		run_cycle(1'b0, '0, 1'b1);
		idle(3);
		compare_status(make_status(0, 1'b0), status);
	endtask

	task automatic test_interleaved();
		logic	w;
		test_name = "interleaved";
		for (int i = 0; i < 300; i++)
		begin
			// Never more than 31 unread words
			w = ($urandom() % 2 == 1) && (ref_q.size() < fifo_depth - 1);
			run_cycle(w, fifo_dat_t'($urandom()), $urandom() % 2 == 1);
		end
		// Enough reads to empty a FIFO holding 31 words
		repeat (fifo_depth) run_cycle(1'b0, '0, 1'b1);
		idle(3);
		compare_status(make_status(0, 1'b0), status);
	endtask

	initial
	begin
		void'($urandom(43));
		err_cnt = 0;
		CLK_IN = 1'b1;
		wr = 1'b0;
		rd = 1'b0;
		wr_dat = '0;
		cnt_m = '0;
		full_m = 1'b0;
		acc_d1 = 1'b0;
		word_d1 = '0;
		repeat (16) @(negedge RST_IN);
		CLK_IN = 1'b0;
		test_reset_state();
		test_burst_order();
		test_single_mode();
		test_full_hysteresis();
		test_read_empty();
		test_interleaved();
		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
